// File: Bender.yml
package:
  name: usb_bulk_bridge

sources:
  - include_dirs:
      - .
    files:
      - usb_proto_pkg.sv
      - usb_stream_pkg.sv
      - reset_sync.sv
      - telemetry_fifo.sv
      - in_source_mux.sv
      - axis_skid.sv
      - conf_desc_rom.sv
      - usb_bulk_bridge.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_usb_bulk_bridge.sv

// File: axis_skid.sv
`timescale 1ns/1ps

module axis_skid #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clock,
  input  logic     areset_n,
  input  payload_t s_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  output payload_t m_o,
  output logic     m_valid_o,
  input  logic     m_ready_i
);

  payload_t main_q;
  payload_t skid_q;
  logic     main_valid_q;
  logic     skid_valid_q;
  logic     ready_q;
  logic     s_fire_w;
  logic     main_free_w;
  logic     main_valid_d;
  logic     skid_valid_d;

  assign s_fire_w    = s_valid_i & ready_q;
  assign main_free_w = ~main_valid_q | m_ready_i;

  always_comb begin
    main_valid_d = main_valid_q;
    skid_valid_d = skid_valid_q;
    if (main_free_w) begin
      main_valid_d = skid_valid_q | s_fire_w;
      skid_valid_d = 1'b0;
    end else if (s_fire_w) begin
      skid_valid_d = 1'b1;  // Output stalled, park the beat
    end
  end

  always_ff @(posedge clock) begin
    if (main_free_w) begin
      main_q <= skid_valid_q ? skid_q : s_i;
    end else if (s_fire_w) begin
      skid_q <= s_i;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      ready_q      <= ~skid_valid_d;  // Low only with both entries full
    end
  end

  assign s_ready_o = ready_q;
  assign m_o       = main_q;
  assign m_valid_o = main_valid_q;

  a_hold_stable : assert property (
    @(posedge clock) disable iff (!areset_n)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_o)
  );

endmodule

// File: conf_desc_rom.sv
`timescale 1ns/1ps
`include "usb_bridge_cfg.svh"

module conf_desc_rom (
  input  logic                       clock,
  input  logic                       areset_n,
  input  logic                       desc_start_i,
  input  usb_proto_pkg::wlength_t    desc_length_i,
  output usb_stream_pkg::desc_beat_t m_desc_o,
  output logic                       m_desc_valid_o,
  input  logic                       m_desc_ready_i
);
  import usb_proto_pkg::*;

  localparam logic [7:0] DESC_TABLE [`CONF_DESC_BYTES] = '{
    // Configuration
    8'h09, 8'h02, 8'(`CONF_DESC_BYTES), 8'(`CONF_DESC_BYTES >> 8),
    `CFG_NUM_INTERFACES, `CFG_VALUE, 8'h00, `CFG_ATTRIBUTES, `CFG_MAX_POWER,
    // Interface 0
    8'h09, 8'h04, 8'h00, 8'h00, `IF_NUM_ENDPOINTS, 8'h00, 8'h00, 8'h00, 8'h00,
    // Bulk endpoints, max packet little-endian
    8'h07, 8'h05, `EP1_IN_ADDR, `EP_ATTR_BULK,
    8'(`EP_MAX_PACKET), 8'(`EP_MAX_PACKET >> 8), 8'h00,
    8'h07, 8'h05, `EP1_OUT_ADDR, `EP_ATTR_BULK,
    8'(`EP_MAX_PACKET), 8'(`EP_MAX_PACKET >> 8), 8'h00,
    8'h07, 8'h05, `EP2_IN_ADDR, `EP_ATTR_BULK,
    8'(`EP_MAX_PACKET), 8'(`EP_MAX_PACKET >> 8), 8'h00
  };

  logic [5:0] idx_q;
  logic [5:0] end_q;
  logic       busy_q;
  logic       start_w;
  logic       fire_w;
  wlength_t   clamp_w;

  assign start_w = desc_start_i & ~busy_q & (desc_length_i != '0);  // Zero length sends nothing
  assign fire_w  = m_desc_valid_o & m_desc_ready_i;
  assign clamp_w = (desc_length_i > wlength_t'(`CONF_DESC_BYTES)) ?
                   wlength_t'(`CONF_DESC_BYTES) : desc_length_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
      end_q  <= '0;
    end else if (start_w) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
      end_q  <= 6'(clamp_w - 1'b1);
    end else if (fire_w) begin
      if (idx_q == end_q) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign m_desc_valid_o = busy_q;
  assign m_desc_o.data  = DESC_TABLE[idx_q];
  assign m_desc_o.last  = (idx_q == end_q);

  // A start during a transfer must not restart the index
  a_busy_start : assert property (
    @(posedge clock) disable iff (!areset_n)
    desc_start_i && busy_q && !fire_w |=> idx_q == $past(idx_q)
  );

  a_idx_range : assert property (
    @(posedge clock) disable iff (!areset_n)
    busy_q |-> idx_q <= end_q && end_q < 6'(`CONF_DESC_BYTES)
  );

endmodule

// File: in_source_mux.sv
`timescale 1ns/1ps
`include "usb_bridge_cfg.svh"

module in_source_mux (
  input  logic                               clock,
  input  logic                               areset_n,
  input  usb_proto_pkg::endpoint_t           blk_endpt_i,
  input  logic                               blk_in_ready_i,
  input  logic [$clog2(`TELE_DEPTH + 1)-1:0] tele_level_i,
  input  usb_stream_pkg::bulk_beat_t         tele_i,
  input  logic                               tele_valid_i,
  output logic                               tele_ready_o,
  input  usb_stream_pkg::bulk_beat_t         user_i,
  input  logic                               user_valid_i,
  output logic                               user_ready_o,
  output usb_stream_pkg::bulk_beat_t         out_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic                               blk_in_ready_o,
  output logic                               has_telemetry_o
);

  logic tele_sel_q;
  logic blk_in_ready_q;
  logic has_tele_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_q <= 1'b0;
      has_tele_q     <= 1'b0;
    end else begin
      tele_sel_q     <= (blk_endpt_i == `TELE_ENDPOINT);
      // A full telemetry FIFO is always ready to send
      blk_in_ready_q <= blk_in_ready_i || (tele_level_i >= `TELE_FULL_LEVEL);
      has_tele_q     <= (tele_level_i >= `TELE_HAS_LEVEL);
    end
  end

  assign out_o        = tele_sel_q ? tele_i : user_i;
  assign out_valid_o  = tele_sel_q ? tele_valid_i : user_valid_i;
  assign tele_ready_o = tele_sel_q & out_ready_i;
  assign user_ready_o = ~tele_sel_q & out_ready_i;  // Held off when unselected

  assign blk_in_ready_o  = blk_in_ready_q;
  assign has_telemetry_o = has_tele_q;

endmodule

// File: list.f
+incdir+.
usb_proto_pkg.sv
usb_stream_pkg.sv
reset_sync.sv
telemetry_fifo.sv
in_source_mux.sv
axis_skid.sv
conf_desc_rom.sv
usb_bulk_bridge.sv
tb_clock_gen.sv
tb_usb_bulk_bridge.sv

// File: reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
  input  logic clock,
  input  logic areset_n,
  input  logic bus_reset_i,
  output logic phy_rst_n_o,
  output logic core_rst_n_o
);

  logic [3:0] chain_q;
  logic       bus_rst_q;  // Stretches a bus reset pulse by one cycle

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      chain_q   <= 4'h0;
      bus_rst_q <= 1'b0;
    end else begin
      bus_rst_q  <= bus_reset_i;
      chain_q[0] <= 1'b1;
      chain_q[1] <= chain_q[0];
      chain_q[2] <= chain_q[1];
      // Core held off while the bus reset is pending
      chain_q[3] <= chain_q[2] & ~bus_reset_i & ~bus_rst_q;
    end
  end

  assign phy_rst_n_o  = chain_q[1];
  assign core_rst_n_o = chain_q[3];

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 20.0
) (
  output logic clock_o
);

  initial begin
    clock_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clock_o = ~clock_o;
    end
  end

endmodule

// File: tb_usb_bulk_bridge.sv
`timescale 1ns/1ps
`include "usb_bridge_cfg.svh"

module tb_usb_bulk_bridge;
  import usb_proto_pkg::*;
  import usb_stream_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  // Expected configuration descriptor, byte by byte
  localparam logic [7:0] CONF_BYTES [39] = '{
    8'h09, 8'h02, 8'h27, 8'h00, 8'h01, 8'h01, 8'h00, 8'hC0, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h03, 8'h00, 8'h00, 8'h00, 8'h00,
    8'h07, 8'h05, 8'h81, 8'h02, 8'h00, 8'h02, 8'h00,
    8'h07, 8'h05, 8'h01, 8'h02, 8'h00, 8'h02, 8'h00,
    8'h07, 8'h05, 8'h82, 8'h02, 8'h00, 8'h02, 8'h00
  };

  logic       clock;
  logic       areset_n;
  logic       reset_no;
  logic       bus_reset_i;
  logic       sof_i;
  logic       crc_err_i;
  endpoint_t  blk_endpt_i;
  logic       blk_in_ready_i;
  logic       blk_in_ready_o;
  logic       has_telemetry_o;
  bulk_beat_t s_bulk_i;
  logic       s_bulk_valid_i;
  logic       s_bulk_ready_o;
  bulk_beat_t m_bulk_o;
  logic       m_bulk_valid_o;
  logic       m_bulk_ready_i;
  logic       desc_start_i;
  wlength_t   desc_length_i;
  desc_beat_t m_desc_o;
  logic       m_desc_valid_o;
  logic       m_desc_ready_i;

  integer     seed;
  int         cycles;
  int         rel_cnt;     // Edges seen since areset_n went high
  int         occ;         // Model FIFO occupancy, event phase only
  logic [3:0] seq;
  logic       tele_mode;
  logic       flags_on;
  logic       bulk_have;
  logic       desc_have;
  bulk_beat_t bulk_exp;
  desc_beat_t desc_exp;
  bulk_beat_t bulk_q [$];
  logic [7:0] tele_q [$];
  logic [7:0] desc_q [$];

  tb_clock_gen #(.PERIOD_NS(20.0)) i_tb_clock_gen (.clock_o(clock));

  usb_bulk_bridge i_usb_bulk_bridge (
    .clock           (clock),
    .areset_n        (areset_n),
    .reset_no        (reset_no),
    .bus_reset_i     (bus_reset_i),
    .sof_i           (sof_i),
    .crc_err_i       (crc_err_i),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o),
    .s_bulk_i        (s_bulk_i),
    .s_bulk_valid_i  (s_bulk_valid_i),
    .s_bulk_ready_o  (s_bulk_ready_o),
    .m_bulk_o        (m_bulk_o),
    .m_bulk_valid_o  (m_bulk_valid_o),
    .m_bulk_ready_i  (m_bulk_ready_i),
    .desc_start_i    (desc_start_i),
    .desc_length_i   (desc_length_i),
    .m_desc_o        (m_desc_o),
    .m_desc_valid_o  (m_desc_valid_o),
    .m_desc_ready_i  (m_desc_ready_i)
  );

  task automatic abort_run(input string why);
    if (why != "") begin
      $display("%s", why);
    end
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run("");
  endtask

  // Reference models, updated at each edge from sampled signals
  always @(posedge clock) begin
    logic [3:0] code;
    int         n;
    if (m_bulk_valid_o && m_bulk_ready_i) begin
      if (tele_mode && tele_q.size() != 0) begin
        void'(tele_q.pop_front());
      end else if (!tele_mode && bulk_q.size() != 0) begin
        void'(bulk_q.pop_front());
      end
    end
    if (m_desc_valid_o && m_desc_ready_i && desc_q.size() != 0) begin
      void'(desc_q.pop_front());
    end
    if (s_bulk_valid_i && s_bulk_ready_o) begin
      bulk_q.push_back(s_bulk_i);
    end
    if ((sof_i || crc_err_i || bus_reset_i) && occ < `TELE_DEPTH) begin  // Full drops it
      code = bus_reset_i ? 4'd3 : (crc_err_i ? 4'd2 : 4'd1);
      tele_q.push_back({code, seq});
      seq = seq + 4'd1;
      occ = occ + 1;
    end
    if (desc_start_i) begin
      n = (desc_length_i > 16'd39) ? 39 : int'(desc_length_i);
      for (int i = 0; i < n; i++) begin
        desc_q.push_back(CONF_BYTES[i]);
      end
    end
    if (bus_reset_i) begin
      // Core reset flushes both stream paths
      bulk_q.delete();
      desc_q.delete();
    end
    if (tele_mode) begin
      bulk_have = (tele_q.size() != 0);
      if (bulk_have) begin
        bulk_exp = '{data: tele_q[0], keep: 1'b1, last: (tele_q.size() == 1)};
      end
    end else begin
      bulk_have = (bulk_q.size() != 0);
      if (bulk_have) begin
        bulk_exp = bulk_q[0];
      end
    end
    desc_have = (desc_q.size() != 0);
    if (desc_have) begin
      desc_exp = '{data: desc_q[0], last: (desc_q.size() == 1)};
    end
  end

  always @(posedge clock) begin
    if (areset_n && rel_cnt < 15) begin
      rel_cnt <= rel_cnt + 1;
    end
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("Timeout, the tests did not finish within the cycle limit");
    end
  end

  // Random back-pressure and bulk IN readiness
  always @(posedge clock) begin
    m_bulk_ready_i <= ($random(seed) & 3) != 0;
    m_desc_ready_i <= ($random(seed) & 3) != 0;
    blk_in_ready_i <= ($random(seed) & 7) == 0;
  end

  a_reset_quiet : assert property (@(posedge clock)
    cycles != 0 && rel_cnt < 4 |-> !m_bulk_valid_o && !m_desc_valid_o && !s_bulk_ready_o &&
                                   !blk_in_ready_o && !has_telemetry_o)
    else abort_run("Outputs were active while the core was in reset");
  a_phy_low : assert property (@(posedge clock) cycles != 0 && rel_cnt < 2 |-> !reset_no)
    else abort_run("reset_no released too early");
  a_phy_high : assert property (@(posedge clock) rel_cnt >= 2 |-> reset_no)
    else abort_run("reset_no did not release on the second edge");
  a_bulk_extra : assert property (@(posedge clock) m_bulk_valid_o |-> bulk_have)
    else abort_run("Bulk output presented a beat that was never expected");
  a_bulk_data : assert property (@(posedge clock)
    m_bulk_valid_o && m_bulk_ready_i |-> m_bulk_o == bulk_exp)
    else value_mismatch("m_bulk_o", $sampled(m_bulk_o), $sampled(bulk_exp));
  a_desc_extra : assert property (@(posedge clock) m_desc_valid_o |-> desc_have)
    else abort_run("Descriptor output presented a byte that was never expected");
  a_desc_data : assert property (@(posedge clock)
    m_desc_valid_o && m_desc_ready_i |-> m_desc_o == desc_exp)
    else value_mismatch("m_desc_o", $sampled(m_desc_o), $sampled(desc_exp));
  a_user_blocked : assert property (@(posedge clock) tele_mode |=> !s_bulk_ready_o)
    else abort_run("User stream was ready while the telemetry endpoint was selected");
  a_has_tele : assert property (@(posedge clock) flags_on && $past(flags_on) |->
    has_telemetry_o == ($past(occ) >= `TELE_HAS_LEVEL))
    else value_mismatch("has_telemetry_o", $sampled(has_telemetry_o),
                        $past(occ) >= `TELE_HAS_LEVEL);
  a_blk_ready : assert property (@(posedge clock) flags_on && $past(flags_on) |->
    blk_in_ready_o == ($past(blk_in_ready_i) || $past(occ) >= `TELE_FULL_LEVEL))
    else value_mismatch("blk_in_ready_o", $sampled(blk_in_ready_o),
                        $past(blk_in_ready_i) || $past(occ) >= `TELE_FULL_LEVEL);
  a_bus_reset : assert property (@(posedge clock)
    bus_reset_i |=> !m_bulk_valid_o && !m_desc_valid_o)
    else abort_run("A stream stayed valid during the bus reset");

  task automatic send_user(input int beats);
    for (int i = 0; i < beats; i++) begin
      s_bulk_valid_i <= 1'b1;
      s_bulk_i       <= bulk_beat_t'($random(seed));
      @(posedge clock);
      while (!s_bulk_ready_o) begin
        @(posedge clock);
      end
      s_bulk_valid_i <= 1'b0;
      if ($random(seed) & 1) begin
        @(posedge clock);  // Idle gap
      end
    end
    s_bulk_valid_i <= 1'b0;
    @(posedge clock);
    while (bulk_q.size() != 0) begin
      @(posedge clock);
    end
  endtask

  task automatic read_descriptor(input wlength_t length);
    desc_start_i  <= 1'b1;
    desc_length_i <= length;
    @(posedge clock);
    desc_start_i <= 1'b0;
    @(posedge clock);
    while (desc_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
  endtask

  task automatic apply_event(input logic sof, input logic crc, input logic bus);
    sof_i       <= sof;
    crc_err_i   <= crc;
    bus_reset_i <= bus;
    @(posedge clock);
  endtask

  initial begin
    seed           = 1137;
    cycles         = 0;
    rel_cnt        = 0;
    occ            = 0;
    seq            = 4'h0;
    tele_mode      = 1'b0;
    flags_on       = 1'b0;
    bulk_have      = 1'b0;
    desc_have      = 1'b0;
    areset_n       = 1'b0;
    bus_reset_i    = 1'b0;
    sof_i          = 1'b0;
    crc_err_i      = 1'b0;
    blk_endpt_i    = 4'd1;
    blk_in_ready_i = 1'b0;
    s_bulk_i       = '0;
    s_bulk_valid_i = 1'b0;
    m_bulk_ready_i = 1'b0;
    desc_start_i   = 1'b0;
    desc_length_i  = '0;
    m_desc_ready_i = 1'b0;
    repeat (8) @(posedge clock);
    areset_n <= 1'b1;
    repeat (8) @(posedge clock);
    flags_on <= 1'b1;

    send_user(40);
    read_descriptor(16'd0);
    read_descriptor(16'd9);
    read_descriptor(16'd39);
    read_descriptor(16'd255);

    apply_event(1'b1, 1'b0, 1'b0);
    apply_event(1'b0, 1'b1, 1'b0);
    apply_event(1'b1, 1'b1, 1'b0);  // CRC wins
    apply_event(1'b0, 1'b0, 1'b0);
    flags_on      <= 1'b0;          // Core registers clear during bus reset
    desc_start_i  <= 1'b1;          // Descriptor read cut short by the bus reset
    desc_length_i <= 16'd39;
    @(posedge clock);
    desc_start_i <= 1'b0;
    repeat (2) @(posedge clock);
    apply_event(1'b1, 1'b0, 1'b1);
    apply_event(1'b0, 1'b0, 1'b0);
    repeat (6) @(posedge clock);
    flags_on <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      apply_event(1'b1, ($random(seed) & 1) != 0, 1'b0);  // Runs past full
    end
    apply_event(1'b0, 1'b0, 1'b0);
    repeat (3) @(posedge clock);

    flags_on    <= 1'b0;
    tele_mode   <= 1'b1;
    blk_endpt_i <= `TELE_ENDPOINT;
    @(posedge clock);
    while (tele_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (6) @(posedge clock);

    if (bulk_q.size() != 0 || desc_q.size() != 0 || occ != `TELE_DEPTH) begin
      abort_run("Expected traffic was not fully seen");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: telemetry_fifo.sv
`timescale 1ns/1ps
`include "usb_bridge_cfg.svh"

module telemetry_fifo (
  input  logic                               clock,
  input  logic                               areset_n,
  input  logic                               sof_i,
  input  logic                               crc_err_i,
  input  logic                               bus_reset_i,
  output usb_stream_pkg::bulk_beat_t         m_tele_o,
  output logic                               m_tele_valid_o,
  input  logic                               m_tele_ready_i,
  output logic [$clog2(`TELE_DEPTH + 1)-1:0] level_o
);
  import usb_proto_pkg::*;

  localparam int PTR_W = $clog2(`TELE_DEPTH);
  localparam int CNT_W = $clog2(`TELE_DEPTH + 1);

  logic [7:0]       mem_q [`TELE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [3:0]       seq_q;
  tele_event_e      event_w;
  logic             any_event_w;
  logic             push_w;
  logic             pop_w;

  // Bus reset wins over CRC, CRC over SOF
  always_comb begin
    event_w = EV_SOF;
    if (bus_reset_i) begin
      event_w = EV_BUS_RESET;
    end else if (crc_err_i) begin
      event_w = EV_CRC;
    end
  end

  assign any_event_w = sof_i | crc_err_i | bus_reset_i;
  assign push_w      = any_event_w && (count_q != CNT_W'(`TELE_DEPTH));  // Dropped when full
  assign pop_w       = m_tele_valid_o & m_tele_ready_i;

  always_ff @(posedge clock) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= {event_w, seq_q};
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      seq_q    <= 4'h0;
    end else begin
      if (push_w) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`TELE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        seq_q    <= seq_q + 4'd1;  // Only logged events count
      end
      if (pop_w) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`TELE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign m_tele_valid_o = (count_q != '0);
  assign m_tele_o.data  = mem_q[rd_ptr_q];
  assign m_tele_o.keep  = 1'b1;
  assign m_tele_o.last  = (count_q == CNT_W'(1));  // Only byte stored
  assign level_o        = count_q;

  a_count_bound : assert property (
    @(posedge clock) disable iff (!areset_n)
    count_q <= CNT_W'(`TELE_DEPTH)
  );

endmodule

// File: usb_bridge_cfg.svh
`ifndef USB_BRIDGE_CFG_SVH
`define USB_BRIDGE_CFG_SVH

// Telemetry endpoint and FIFO
`define TELE_ENDPOINT 4'd2
`define TELE_DEPTH 16
`define TELE_HAS_LEVEL 4    // Presence threshold in bytes
`define TELE_FULL_LEVEL 16  // Bulk IN forced ready from here

// Configuration descriptor, one configuration with one interface
`define CONF_DESC_BYTES 39
`define CFG_NUM_INTERFACES 8'h01
`define CFG_VALUE 8'h01
`define CFG_ATTRIBUTES 8'hC0  // Self-powered
`define CFG_MAX_POWER 8'h32   // 100 mA in 2 mA units
`define IF_NUM_ENDPOINTS 8'h03

// Endpoint descriptor fields
`define EP_ATTR_BULK 8'h02
`define EP_MAX_PACKET 16'h0200
`define EP1_IN_ADDR 8'h81
`define EP1_OUT_ADDR 8'h01
`define EP2_IN_ADDR 8'h82

`endif

// File: usb_bulk_bridge.sv
`timescale 1ns/1ps
`include "usb_bridge_cfg.svh"

module usb_bulk_bridge (
  input  logic                       clock,
  input  logic                       areset_n,
  output logic                       reset_no,
  input  logic                       bus_reset_i,
  input  logic                       sof_i,
  input  logic                       crc_err_i,
  input  usb_proto_pkg::endpoint_t   blk_endpt_i,
  input  logic                       blk_in_ready_i,
  output logic                       blk_in_ready_o,
  output logic                       has_telemetry_o,
  input  usb_stream_pkg::bulk_beat_t s_bulk_i,
  input  logic                       s_bulk_valid_i,
  output logic                       s_bulk_ready_o,
  output usb_stream_pkg::bulk_beat_t m_bulk_o,
  output logic                       m_bulk_valid_o,
  input  logic                       m_bulk_ready_i,
  input  logic                       desc_start_i,
  input  usb_proto_pkg::wlength_t    desc_length_i,
  output usb_stream_pkg::desc_beat_t m_desc_o,
  output logic                       m_desc_valid_o,
  input  logic                       m_desc_ready_i
);
  import usb_stream_pkg::*;

  logic                               core_rst_n;
  logic [$clog2(`TELE_DEPTH + 1)-1:0] tele_level;
  bulk_beat_t                         tele_beat;
  logic                               tele_valid;
  logic                               tele_ready;
  bulk_beat_t                         mux_beat;
  logic                               mux_valid;
  logic                               mux_ready;
  desc_beat_t                         rom_beat;
  logic                               rom_valid;
  logic                               rom_ready;

  reset_sync i_reset_sync (
    .clock        (clock),
    .areset_n     (areset_n),
    .bus_reset_i  (bus_reset_i),
    .phy_rst_n_o  (reset_no),
    .core_rst_n_o (core_rst_n)
  );

  // Runs on the PHY reset so a bus reset still gets logged
  telemetry_fifo i_telemetry_fifo (
    .clock          (clock),
    .areset_n       (reset_no),
    .sof_i          (sof_i),
    .crc_err_i      (crc_err_i),
    .bus_reset_i    (bus_reset_i),
    .m_tele_o       (tele_beat),
    .m_tele_valid_o (tele_valid),
    .m_tele_ready_i (tele_ready),
    .level_o        (tele_level)
  );

  in_source_mux i_in_source_mux (
    .clock           (clock),
    .areset_n        (core_rst_n),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .tele_level_i    (tele_level),
    .tele_i          (tele_beat),
    .tele_valid_i    (tele_valid),
    .tele_ready_o    (tele_ready),
    .user_i          (s_bulk_i),
    .user_valid_i    (s_bulk_valid_i),
    .user_ready_o    (s_bulk_ready_o),
    .out_o           (mux_beat),
    .out_valid_o     (mux_valid),
    .out_ready_i     (mux_ready),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o)
  );

  axis_skid #(
    .payload_t (bulk_beat_t)
  ) i_bulk_skid (
    .clock     (clock),
    .areset_n  (core_rst_n),
    .s_i       (mux_beat),
    .s_valid_i (mux_valid),
    .s_ready_o (mux_ready),
    .m_o       (m_bulk_o),
    .m_valid_o (m_bulk_valid_o),
    .m_ready_i (m_bulk_ready_i)
  );

  conf_desc_rom i_conf_desc_rom (
    .clock          (clock),
    .areset_n       (core_rst_n),
    .desc_start_i   (desc_start_i),
    .desc_length_i  (desc_length_i),
    .m_desc_o       (rom_beat),
    .m_desc_valid_o (rom_valid),
    .m_desc_ready_i (rom_ready)
  );

  axis_skid #(
    .payload_t (desc_beat_t)
  ) i_desc_skid (
    .clock     (clock),
    .areset_n  (core_rst_n),
    .s_i       (rom_beat),
    .s_valid_i (rom_valid),
    .s_ready_o (rom_ready),
    .m_o       (m_desc_o),
    .m_valid_o (m_desc_valid_o),
    .m_ready_i (m_desc_ready_i)
  );

endmodule

// File: usb_proto_pkg.sv
package usb_proto_pkg;

  // Endpoint number from token packets
  typedef logic [3:0] endpoint_t;

  // wLength field of a setup request
  typedef logic [15:0] wlength_t;

  // Codes in the upper nibble of a telemetry byte
  typedef enum logic [3:0] {
    EV_SOF       = 4'd1,
    EV_CRC       = 4'd2,
    EV_BUS_RESET = 4'd3
  } tele_event_e;

endpackage

// File: usb_stream_pkg.sv
package usb_stream_pkg;

  // Bulk IN beat, user and telemetry streams
  typedef struct packed {
    logic [7:0] data;
    logic       keep;
    logic       last;
  } bulk_beat_t;

  // Descriptor beat, no keep
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } desc_beat_t;

endpackage
